// File: verilog/video_macros.svh
/*
 * video raster constants
 * raster sizes, porches, colour bar geometry and line buffer depth
 */

`ifndef VIDEO_MACROS_SVH
`define VIDEO_MACROS_SVH

// raster totals, 204800 clocks per frame
`define VID_H_TOTAL     400
`define VID_V_TOTAL     512

// visible area and its offset from line/frame start
`define VID_H_ACTIVE    320
`define VID_V_ACTIVE    240
`define VID_H_BPORCH    10
`define VID_V_BPORCH    10

// hsync sits a few clocks after line start, clear of vsync
`define VID_HS_OFFSET   3

// colour bars: 8 bars across, pattern steps right every 30 lines
`define VID_BAR_WIDTH   40
`define VID_BAR_HEIGHT  30

// two full lines, ping-pong halves
`define VID_BUF_DEPTH   640
`define VID_ADDR_W      10

`endif

// File: verilog/video_pkg.sv
/*
 * video types
 * pixel and coordinate types, colour bar table and overlay colour
 */

`include "video_macros.svh"

package video_pkg;

    // red in [23:16], green in [15:8], blue in [7:0]
    typedef logic [23:0] rgb_t;

    // raster x/y and line buffer address share one width
    typedef logic [`VID_ADDR_W-1:0] coord_t;

    // bar colours, left to right on the top bar row
    localparam rgb_t BAR_COLORS [0:7] = '{
        24'hFF_FF_FF,   // white
        24'hFF_FF_00,   // yellow
        24'h00_FF_FF,   // cyan
        24'h00_FF_00,   // green
        24'hFF_00_FF,   // magenta
        24'hFF_00_00,   // red
        24'h00_00_FF,   // blue
        24'h80_80_80    // grey
    };

    // moving line drawn on top of the bars
    localparam rgb_t OVERLAY_COLOR = 24'hFF_FF_FF;

endpackage

// File: verilog/video_timing.sv
/*
 * video timing generator
 * 400 x 512 raster, decodes sync, line fill and line buffer reads
 */

`timescale 1ns/10ps

`include "video_macros.svh"

module video_timing (
    input  logic               clk_sdram,
    input  logic               reset_n,
    output logic               frame_start,
    output logic               fill_start,
    output logic               rd_en,
    output video_pkg::coord_t  rd_addr,
    output logic               pre_vs,
    output logic               pre_hs,
    output logic               pre_active
);

    video_pkg::coord_t x_count;
    video_pkg::coord_t y_count;
    video_pkg::coord_t x_next;
    video_pkg::coord_t y_next;

    ////////////////////////////////////////////////////////////////////////////
    // raster counters
    ////////////////////////////////////////////////////////////////////////////

    // next counter state, decodes below are taken from it so the
    // registered flags line up with the counter cycle they describe
    always_comb begin
        x_next = x_count + 1'b1;
        y_next = y_count;
        if (x_count == `VID_H_TOTAL - 1) begin
            x_next = '0;
            y_next = y_count + 1'b1;
            if (y_count == `VID_V_TOTAL - 1) begin
                y_next = '0;
            end
        end
    end

    always_ff @(posedge clk_sdram or negedge reset_n) begin
        if (!reset_n) begin
            x_count    <= '0;
            y_count    <= '0;
            frame_start <= 1'b0;
            fill_start <= 1'b0;
            pre_hs     <= 1'b0;
            pre_active <= 1'b0;
            rd_en      <= 1'b0;
        end else begin
            x_count <= x_next;
            y_count <= y_next;

            // frame restart at (0,0)
            frame_start <= (x_next == 0) && (y_next == 0);

            // fill the line before each visible one
            fill_start <= (x_next == 0) &&
                          (y_next >= `VID_V_BPORCH - 1) &&
                          (y_next < `VID_V_BPORCH + `VID_V_ACTIVE - 1);

            // hsync every line
            pre_hs <= (x_next == `VID_HS_OFFSET);

            // visible window
            pre_active <= (x_next >= `VID_H_BPORCH) &&
                          (x_next < `VID_H_BPORCH + `VID_H_ACTIVE) &&
                          (y_next >= `VID_V_BPORCH) &&
                          (y_next < `VID_V_BPORCH + `VID_V_ACTIVE);

            // reads run one pixel ahead, buffer data lands with pre_active
            rd_en <= (x_next >= `VID_H_BPORCH - 1) &&
                     (x_next < `VID_H_BPORCH + `VID_H_ACTIVE - 1) &&
                     (y_next >= `VID_V_BPORCH) &&
                     (y_next < `VID_V_BPORCH + `VID_V_ACTIVE);
        end
    end

    // vsync is the frame restart itself
    assign pre_vs = frame_start;

    ////////////////////////////////////////////////////////////////////////////
    // read address
    ////////////////////////////////////////////////////////////////////////////

    // steps only after an actual read, wraps over both halves
    always_ff @(posedge clk_sdram or negedge reset_n) begin
        if (!reset_n) begin
            rd_addr <= '0;
        end else if (frame_start) begin
            rd_addr <= '0;
        end else if (rd_en) begin
            if (rd_addr == `VID_BUF_DEPTH - 1) begin
                rd_addr <= '0;
            end else begin
                rd_addr <= rd_addr + 1'b1;
            end
        end
    end

endmodule

// File: verilog/line_buffer.sv
/*
 * line buffer
 * two-line simple dual-port memory, registered read
 */

`timescale 1ns/10ps

`include "video_macros.svh"

module line_buffer #(
    parameter type payload_t = logic
) (
    input  logic               clk_sdram,
    input  logic               wr_en,
    input  video_pkg::coord_t  wr_addr,
    input  payload_t           wr_data,
    input  logic               rd_en,
    input  video_pkg::coord_t  rd_addr,
    output payload_t           rd_data
);

    // one half is read while the other half fills
    payload_t mem [0:`VID_BUF_DEPTH-1];

    always_ff @(posedge clk_sdram) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // holds last value between reads
    always_ff @(posedge clk_sdram) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// File: verilog/line_fill.sv
/*
 * line filler
 * writes one line of colour bars and the overlay flag per fill pulse
 */

`timescale 1ns/10ps

`include "video_macros.svh"

module line_fill (
    input  logic               clk_sdram,
    input  logic               reset_n,
    input  logic               frame_start,
    input  logic               fill_start,
    output logic               wr_en,
    output video_pkg::coord_t  wr_addr,
    output video_pkg::rgb_t    pattern_data,
    output logic               overlay_data
);

    video_pkg::coord_t col;
    video_pkg::coord_t line;
    video_pkg::coord_t frame_index;
    logic              frame_seen;
    logic [2:0]        bar_sel;

    ////////////////////////////////////////////////////////////////////////////
    // column, line and frame tracking
    ////////////////////////////////////////////////////////////////////////////

    // one pixel per cycle after fill_start, 320 in total
    always_ff @(posedge clk_sdram or negedge reset_n) begin
        if (!reset_n) begin
            wr_en <= 1'b0;
            col   <= '0;
            line  <= '0;
        end else begin
            if (frame_start) begin
                line <= '0;
            end
            if (fill_start) begin
                wr_en <= 1'b1;
                col   <= '0;
            end else if (wr_en) begin
                col <= col + 1'b1;
                // last pixel of the line
                if (col == `VID_H_ACTIVE - 1) begin
                    wr_en <= 1'b0;
                    line  <= line + 1'b1;
                end
            end
        end
    end

    // write pointer, same wrap as the read side
    always_ff @(posedge clk_sdram or negedge reset_n) begin
        if (!reset_n) begin
            wr_addr <= '0;
        end else if (frame_start) begin
            wr_addr <= '0;
        end else if (wr_en) begin
            if (wr_addr == `VID_BUF_DEPTH - 1) begin
                wr_addr <= '0;
            end else begin
                wr_addr <= wr_addr + 1'b1;
            end
        end
    end

    // overlay column, first frame_start after reset keeps column 0
    always_ff @(posedge clk_sdram or negedge reset_n) begin
        if (!reset_n) begin
            frame_index <= '0;
            frame_seen  <= 1'b0;
        end else if (frame_start) begin
            frame_seen <= 1'b1;
            if (frame_seen) begin
                if (frame_index == `VID_H_ACTIVE - 1) begin
                    frame_index <= '0;
                end else begin
                    frame_index <= frame_index + 1'b1;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // pixel content
    ////////////////////////////////////////////////////////////////////////////

    // bar number plus row shift, low 3 bits give the mod 8
    assign bar_sel = 3'((col / `VID_BAR_WIDTH) + (line / `VID_BAR_HEIGHT));

    assign pattern_data = video_pkg::BAR_COLORS[bar_sel];
    assign overlay_data = (col == frame_index);

endmodule

// File: verilog/pixel_compose.sv
/*
 * pixel compositor
 * overlay over pattern inside the active area, black outside
 */

`timescale 1ns/10ps

module pixel_compose (
    input  logic             clk_sdram,
    input  logic             reset_n,
    input  logic             pre_vs,
    input  logic             pre_hs,
    input  logic             pre_active,
    input  video_pkg::rgb_t  pattern_pixel,
    input  logic             overlay_pixel,
    output video_pkg::rgb_t  video_rgb,
    output logic             video_de,
    output logic             video_vs,
    output logic             video_hs
);

    video_pkg::rgb_t pixel_mux;

    // overlay wins, blanking forces black
    always_comb begin
        pixel_mux = '0;
        if (pre_active) begin
            if (overlay_pixel) begin
                pixel_mux = video_pkg::OVERLAY_COLOR;
            end else begin
                pixel_mux = pattern_pixel;
            end
        end
    end

    // output register, all pins change on the same edge
    always_ff @(posedge clk_sdram or negedge reset_n) begin
        if (!reset_n) begin
            video_rgb <= '0;
            video_de  <= 1'b0;
            video_vs  <= 1'b0;
            video_hs  <= 1'b0;
        end else begin
            video_rgb <= pixel_mux;
            video_de  <= pre_active;
            video_vs  <= pre_vs;
            video_hs  <= pre_hs;
        end
    end

endmodule

// File: verilog/video_core.sv
/*
 * video core top level
 * timing, line filler, pattern and overlay buffers, compositor
 */

`timescale 1ns/10ps

module video_core (
    input  logic             clk_sdram,
    input  logic             reset_n,
    output video_pkg::rgb_t  video_rgb,
    output logic             video_de,
    output logic             video_vs,
    output logic             video_hs
);

    // timing to filler
    logic              frame_start;
    logic              fill_start;

    // filler to both buffers
    logic              wr_en;
    video_pkg::coord_t wr_addr;
    video_pkg::rgb_t   pattern_data;
    logic              overlay_data;

    // read side, shared by both buffers
    logic              rd_en;
    video_pkg::coord_t rd_addr;
    video_pkg::rgb_t   pattern_pixel;
    logic              overlay_pixel;

    // early syncs, one cycle ahead of the pins
    logic              pre_vs;
    logic              pre_hs;
    logic              pre_active;

    video_timing video_timing_inst (
        .clk_sdram   (clk_sdram),
        .reset_n     (reset_n),
        .frame_start (frame_start),
        .fill_start  (fill_start),
        .rd_en       (rd_en),
        .rd_addr     (rd_addr),
        .pre_vs      (pre_vs),
        .pre_hs      (pre_hs),
        .pre_active  (pre_active)
    );

    line_fill line_fill_inst (
        .clk_sdram    (clk_sdram),
        .reset_n      (reset_n),
        .frame_start  (frame_start),
        .fill_start   (fill_start),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .pattern_data (pattern_data),
        .overlay_data (overlay_data)
    );

    // 24-bit colour bars
    line_buffer #(
        .payload_t (video_pkg::rgb_t)
    ) pattern_buffer (
        .clk_sdram (clk_sdram),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (pattern_data),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_data   (pattern_pixel)
    );

    // 1-bit overlay flag
    line_buffer #(
        .payload_t (logic)
    ) overlay_buffer (
        .clk_sdram (clk_sdram),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (overlay_data),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_data   (overlay_pixel)
    );

    pixel_compose pixel_compose_inst (
        .clk_sdram     (clk_sdram),
        .reset_n       (reset_n),
        .pre_vs        (pre_vs),
        .pre_hs        (pre_hs),
        .pre_active    (pre_active),
        .pattern_pixel (pattern_pixel),
        .overlay_pixel (overlay_pixel),
        .video_rgb     (video_rgb),
        .video_de      (video_de),
        .video_vs      (video_vs),
        .video_hs      (video_hs)
    );

endmodule

// File: tests/video_core_tb.sv
/*
 * video core testbench
 * reset state, sync and active-area timing, bar and overlay pixels
 * checked over three frames after the first vsync
 */

`timescale 1ns/10ps

`include "video_macros.svh"

module video_core_tb;

    localparam int FRAME_CYCLES = `VID_H_TOTAL * `VID_V_TOTAL;
    localparam int WAIT_LIMIT   = FRAME_CYCLES + 2000;
    localparam int FIRST_DE     = `VID_V_BPORCH * `VID_H_TOTAL + `VID_H_BPORCH;
    localparam int NUM_FRAMES   = 3;

    logic        clk_sdram;
    logic        reset_n;
    logic [23:0] video_rgb;
    logic        video_de;
    logic        video_vs;
    logic        video_hs;

    // pins one cycle back for edge detection
    logic prev_vs;
    logic prev_hs;
    logic prev_de;

    int check_count;
    int test_errors [1:5];
    bit timed_out;

    // sync and enable tracking
    int cycle_no;
    int last_hs_rise;
    int de_run_len;
    int de_runs;
    bit hs_seen;
    bit de_seen;

    video_core video_core_inst (
        .clk_sdram (clk_sdram),
        .reset_n   (reset_n),
        .video_rgb (video_rgb),
        .video_de  (video_de),
        .video_vs  (video_vs),
        .video_hs  (video_hs)
    );

    // 40 ns clock
    initial begin
        clk_sdram = 1'b0;
        forever begin
            #20 clk_sdram = ~clk_sdram;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // comparisons and reference colours
    ////////////////////////////////////////////////////////////////////////////

    task automatic compare_level(input int test_no, input string name,
                                 input logic [31:0] expected, input logic [31:0] actual);
        check_count++;
        assert (actual === expected) else begin
            test_errors[test_no]++;
            $display("Mismatch at time %0t: %s expected %0d, got %0d",
                     $time, name, expected, actual);
        end
    endtask

    task automatic compare_colour(input int test_no, input string name,
                                  input logic [23:0] expected, input logic [23:0] actual);
        check_count++;
        assert (actual === expected) else begin
            test_errors[test_no]++;
            $display("Mismatch at time %0t: %s expected %06h, got %06h",
                     $time, name, expected, actual);
        end
    endtask

    // bar index steps every 40 columns and shifts one bar every 30 lines
    function automatic logic [23:0] bar_colour(input int col, input int line);
        int idx;
        idx = ((col / `VID_BAR_WIDTH) + (line / `VID_BAR_HEIGHT)) % 8;
        case (idx)
            0:       bar_colour = 24'hFFFFFF;
            1:       bar_colour = 24'hFFFF00;
            2:       bar_colour = 24'h00FFFF;
            3:       bar_colour = 24'h00FF00;
            4:       bar_colour = 24'hFF00FF;
            5:       bar_colour = 24'hFF0000;
            6:       bar_colour = 24'h0000FF;
            default: bar_colour = 24'h808080;
        endcase
    endfunction

    task automatic check_reset_outputs();
        compare_level(1, "video_vs", 0, video_vs);
        compare_level(1, "video_hs", 0, video_hs);
        compare_level(1, "video_de", 0, video_de);
        compare_colour(1, "video_rgb", 24'h0, video_rgb);
    endtask

    task automatic store_previous();
        prev_vs = video_vs;
        prev_hs = video_hs;
        prev_de = video_de;
    endtask

    task automatic report_test(input int test_no, input string title);
        if (test_errors[test_no] == 0) begin
            $display("test %0d, %s: ok", test_no, title);
        end else begin
            $display("test %0d, %s: %0d errors", test_no, title, test_errors[test_no]);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // per-cycle reference model
    ////////////////////////////////////////////////////////////////////////////

    // x and y are the model's raster position with (0,0) on the vsync cycle
    task automatic check_cycle(input int frame, input int x, input int y,
                               input int frame_cyc);
        int col;
        int line;
        bit in_window;
        in_window = (x >= `VID_H_BPORCH) && (x < `VID_H_BPORCH + `VID_H_ACTIVE) &&
                    (y >= `VID_V_BPORCH) && (y < `VID_V_BPORCH + `VID_V_ACTIVE);
        // vsync and hsync only one cycle wide
        if (prev_vs === 1'b1) begin
            compare_level(2, "video_vs width", 0, video_vs);
        end
        if (prev_hs === 1'b1) begin
            compare_level(2, "video_hs width", 0, video_hs);
        end
        if (video_hs === 1'b1 && prev_hs === 1'b0) begin
            if (last_hs_rise >= 0) begin
                compare_level(2, "video_hs period", `VID_H_TOTAL, cycle_no - last_hs_rise);
            end
            // offset of the first hsync of the frame from vsync
            if (!hs_seen) begin
                compare_level(2, "video_hs after video_vs", `VID_HS_OFFSET, frame_cyc);
            end
            last_hs_rise = cycle_no;
            hs_seen = 1'b1;
        end
        if (video_de === 1'b1 && prev_de === 1'b0) begin
            if (!de_seen) begin
                compare_level(3, "video_de first rise", FIRST_DE, frame_cyc);
            end
            de_seen = 1'b1;
            de_runs++;
            de_run_len = 0;
        end
        if (video_de === 1'b1) begin
            de_run_len++;
        end
        if (video_de === 1'b0 && prev_de === 1'b1) begin
            compare_level(3, "video_de run length", `VID_H_ACTIVE, de_run_len);
        end
        // data enable follows the visible window on every line
        compare_level(3, "video_de", in_window, video_de);
        // black in blanking
        if (video_de !== 1'b1) begin
            compare_colour(3, "video_rgb blanking", 24'h0, video_rgb);
        end else if (in_window) begin
            // visible pixels from the bar and overlay rules
            col  = x - `VID_H_BPORCH;
            line = y - `VID_V_BPORCH;
            if (col == frame % `VID_H_ACTIVE) begin
                compare_colour(5, "video_rgb overlay", 24'hFFFFFF, video_rgb);
            end else begin
                compare_colour(4, "video_rgb bars", bar_colour(col, line), video_rgb);
            end
        end
    endtask

    task automatic start_frame();
        hs_seen = 1'b0;
        de_seen = 1'b0;
        de_runs = 0;
    endtask

    task automatic end_frame(input int frame_cyc);
        compare_level(2, "video_vs period", FRAME_CYCLES, frame_cyc);
        compare_level(3, "video_de runs per frame", `VID_V_ACTIVE, de_runs);
    endtask

    // first vsync after reset leaves its rise in the current sample
    task automatic wait_first_vsync(output bit ok);
        int cycles;
        cycles = 0;
        ok = 1'b0;
        store_previous();
        while (!ok && cycles < WAIT_LIMIT) begin
            @(negedge clk_sdram);
            cycles++;
            if (video_vs === 1'b1 && prev_vs === 1'b0) begin
                ok = 1'b1;
            end else begin
                store_previous();
            end
        end
        if (!ok) begin
            $display("Timeout: no video_vs rise within %0d cycles after reset", WAIT_LIMIT);
            timed_out = 1'b1;
        end
    endtask

    // each frame is a wait for the next vsync rise with its own limit
    task automatic observe_frames(output bit ok);
        int frame;
        int x;
        int y;
        int frame_cyc;
        frame = 0;
        x = 0;
        y = 0;
        frame_cyc = 0;
        ok = 1'b1;
        cycle_no = 0;
        last_hs_rise = -1;
        start_frame();
        check_cycle(frame, x, y, frame_cyc);
        store_previous();
        while (ok && frame < NUM_FRAMES) begin
            @(negedge clk_sdram);
            cycle_no++;
            frame_cyc++;
            x++;
            if (x == `VID_H_TOTAL) begin
                x = 0;
                y++;
            end
            if (video_vs === 1'b1 && prev_vs === 1'b0) begin
                // resync the model on every vsync rise
                end_frame(frame_cyc);
                frame++;
                x = 0;
                y = 0;
                frame_cyc = 0;
                start_frame();
            end else if (frame_cyc > WAIT_LIMIT) begin
                $display("Timeout: no video_vs rise within %0d cycles in frame %0d",
                         WAIT_LIMIT, frame);
                timed_out = 1'b1;
                ok = 1'b0;
            end
            if (ok && frame < NUM_FRAMES) begin
                check_cycle(frame, x, y, frame_cyc);
            end
            store_previous();
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin : main_sequence
        bit ok;
        int total;
        reset_n = 1'b0;
        check_count = 0;
        timed_out = 1'b0;
        foreach (test_errors[i]) begin
            test_errors[i] = 0;
        end
        prev_vs = 1'b0;
        prev_hs = 1'b0;
        prev_de = 1'b0;
        de_run_len = 0;
        start_frame();
        begin : run_tests
            // outputs held low through reset
            repeat (10) begin
                @(negedge clk_sdram);
                check_reset_outputs();
            end
            @(posedge clk_sdram);
            #1 reset_n = 1'b1;
            repeat (2) begin
                @(negedge clk_sdram);
                check_reset_outputs();
            end
            report_test(1, "reset state");
            wait_first_vsync(ok);
            if (!ok) begin
                disable run_tests;
            end
            observe_frames(ok);
            if (!ok) begin
                disable run_tests;
            end
            report_test(2, "vsync and hsync timing");
            report_test(3, "data enable and blanking");
            report_test(4, "colour bars");
            report_test(5, "moving overlay column");
        end
        total = 0;
        foreach (test_errors[i]) begin
            total += test_errors[i];
        end
        $display("checks: %0d, errors: %0d, timeout: %0d", check_count, total, timed_out);
        if (total == 0 && !timed_out) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: flist.f
+incdir+verilog
verilog/video_pkg.sv
verilog/video_timing.sv
verilog/line_buffer.sv
verilog/line_fill.sv
verilog/pixel_compose.sv
verilog/video_core.sv
tests/video_core_tb.sv
